//--- build.f
source/part_buf_pkg.sv
source/part_fsm.sv
source/part_addr_gen.sv
source/part_buffer.sv
source/part_access_ctrl.sv
source/part_buf_top.sv
test/tb_part_buf.sv

//--- source/part_access_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Direct access lock aggregation
// Combines the partition lock, CSR locks and digest state into
// registered read and write locks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module part_access_ctrl
  import part_buf_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  locked_i,
  input  part_access_t          access_i,
  input  logic [BlockWidth-1:0] digest_i,
  output part_access_t          access_o
);

  part_access_t access_d;
  part_access_t access_q;

  always_comb begin
    // Uninitialized or failed partition is fully locked
    access_d.read_lock  = locked_i | access_i.read_lock;
    // A written digest makes the partition read only
    access_d.write_lock = locked_i | access_i.write_lock | (digest_i != '0);
  end

  // Locked out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      access_q <= '{read_lock: 1'b1, write_lock: 1'b1};
    end else begin
      access_q <= access_d;
    end
  end

  assign access_o = access_q;

  locked_blocks_access_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    locked_i |=> access_o.read_lock && access_o.write_lock);

endmodule

//--- source/part_addr_gen.sv
////////////////////////////////////////////////////////////////////////////
// Block counter and OTP address generation
// Up counter with an inverted shadow copy for fault detection
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module part_addr_gen
  import part_buf_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                cnt_clr_i,
  input  logic                cnt_en_i,
  input  logic                req_i,
  output otp_req_t            otp_req_o,
  output logic [CntWidth-1:0] cnt_o,
  output logic                cnt_last_o,
  output logic                cnt_err_o
);

  logic [CntWidth-1:0]      cnt_q;
  logic [CntWidth-1:0]      cnt_n_q;
  logic [ByteAddrWidth-1:0] byte_addr;

  // Shadow counts down from all ones
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q   <= '0;
      cnt_n_q <= '1;
    end else if (cnt_clr_i) begin
      cnt_q   <= '0;
      cnt_n_q <= '1;
    end else if (cnt_en_i) begin
      cnt_q   <= cnt_q + 1'b1;
      cnt_n_q <= cnt_n_q - 1'b1;
    end
  end

  // Copies must stay complementary
  assign cnt_err_o  = (cnt_q != ~cnt_n_q);
  assign cnt_o      = cnt_q;
  assign cnt_last_o = (cnt_q == CntWidth'(NumBlocks - 1));

  // 8 bytes per block, OTP takes halfword addresses
  assign byte_addr      = PartOffset + (ByteAddrWidth'(cnt_q) << $clog2(BlockWidth / 8));
  assign otp_req_o.req  = req_i;
  assign otp_req_o.addr = byte_addr[ByteAddrWidth-1:OtpAddrShift];

  // FSM never steps past the digest block
  cnt_in_range_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_en_i |-> !cnt_last_o);

endmodule

//--- source/part_buf_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Buffered OTP partition definitions
// Partition geometry, OTP macro bus structs, error codes and the
// direct access lock struct shared by all partition blocks
////////////////////////////////////////////////////////////////////////////

package part_buf_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Partition geometry
  ////////////////////////////////////////////////////////////////////////////

  // One block is one raw 64-bit OTP read
  localparam int unsigned BlockWidth = 64;
  // Last block holds the digest
  localparam int unsigned NumBlocks  = 4;
  localparam int unsigned CntWidth   = 2;
  localparam int unsigned PartBytes  = 32;

  // OTP addressing
  localparam int unsigned ByteAddrWidth = 11;
  localparam int unsigned OtpAddrWidth  = 10;
  // Byte to halfword address
  localparam int unsigned OtpAddrShift  = 1;
  localparam logic [ByteAddrWidth-1:0] PartOffset = 11'h040;

  // Value of the data output while the partition is locked
  localparam logic [PartBytes*8-1:0] DataDefault = '0;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  // Error codes as reported by the OTP macro and the partition
  typedef enum logic [2:0] {
    NoError             = 3'h0,
    MacroError          = 3'h1,
    MacroEccCorrError   = 3'h2,
    MacroEccUncorrError = 3'h3,
    CheckFailError      = 3'h4,
    FsmStateError       = 3'h5
  } otp_err_e;

  // Read request towards the OTP macro
  typedef struct packed {
    logic                    req;
    logic [OtpAddrWidth-1:0] addr;
  } otp_req_t;

  // Grant and read response from the OTP macro
  typedef struct packed {
    logic                  gnt;
    logic                  rvalid;
    logic [BlockWidth-1:0] rdata;
    otp_err_e              err;
  } otp_rsp_t;

  // Direct access locks, high means locked
  typedef struct packed {
    logic read_lock;
    logic write_lock;
  } part_access_t;

endpackage

//--- source/part_buf_top.sv
////////////////////////////////////////////////////////////////////////////
// Buffered read-only OTP partition
// Connects the control FSM, address generator, block buffer and
// access lock logic
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module part_buf_top
  import part_buf_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Control
  input  logic                   init_req_i,
  output logic                   init_done_o,
  input  logic                   cnsty_chk_req_i,
  output logic                   cnsty_chk_ack_o,
  input  logic                   escalate_en_i,
  // Status
  output otp_err_e               error_o,
  output logic                   fsm_err_o,
  // Locks
  input  part_access_t           access_i,
  output part_access_t           access_o,
  // Buffered contents
  output logic [PartBytes*8-1:0] data_o,
  output logic [BlockWidth-1:0]  digest_o,
  // OTP macro
  output otp_req_t               otp_req_o,
  input  otp_rsp_t               otp_rsp_i
);

  logic                  otp_req;
  logic                  cnt_clr;
  logic                  cnt_en;
  logic [CntWidth-1:0]   cnt;
  logic                  cnt_last;
  logic                  cnt_err;
  logic                  buf_wr_en;
  logic                  locked;
  logic [BlockWidth-1:0] blk_rdata;

  part_fsm part_fsm_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .init_req_i      (init_req_i),
    .cnsty_chk_req_i (cnsty_chk_req_i),
    .escalate_en_i   (escalate_en_i),
    .otp_rsp_i       (otp_rsp_i),
    .blk_rdata_i     (blk_rdata),
    .cnt_last_i      (cnt_last),
    .cnt_err_i       (cnt_err),
    .otp_req_o       (otp_req),
    .cnt_clr_o       (cnt_clr),
    .cnt_en_o        (cnt_en),
    .buf_wr_en_o     (buf_wr_en),
    .locked_o        (locked),
    .init_done_o     (init_done_o),
    .cnsty_chk_ack_o (cnsty_chk_ack_o),
    .error_o         (error_o),
    .fsm_err_o       (fsm_err_o)
  );

  part_addr_gen part_addr_gen_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cnt_clr_i  (cnt_clr),
    .cnt_en_i   (cnt_en),
    .req_i      (otp_req),
    .otp_req_o  (otp_req_o),
    .cnt_o      (cnt),
    .cnt_last_o (cnt_last),
    .cnt_err_o  (cnt_err)
  );

  // Raw OTP read data goes straight into the buffer
  part_buffer part_buffer_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wr_en_i  (buf_wr_en),
    .addr_i   (cnt),
    .wdata_i  (otp_rsp_i.rdata),
    .locked_i (locked),
    .rdata_o  (blk_rdata),
    .data_o   (data_o),
    .digest_o (digest_o)
  );

  part_access_ctrl part_access_ctrl_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .locked_i (locked),
    .access_i (access_i),
    .digest_i (digest_o),
    .access_o (access_o)
  );

endmodule

//--- source/part_buffer.sv
////////////////////////////////////////////////////////////////////////////
// Partition block buffer
// Holds the partition contents, gates the data output while locked
// and exposes the digest block
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module part_buffer
  import part_buf_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   wr_en_i,
  input  logic [CntWidth-1:0]    addr_i,
  input  logic [BlockWidth-1:0]  wdata_i,
  input  logic                   locked_i,
  output logic [BlockWidth-1:0]  rdata_o,
  output logic [PartBytes*8-1:0] data_o,
  output logic [BlockWidth-1:0]  digest_o
);

  // Block 0 in the low bits
  logic [NumBlocks-1:0][BlockWidth-1:0] blk_q;

  // Cleared so the digest reads blank until init
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      blk_q <= '0;
    end else if (wr_en_i) begin
      blk_q[addr_i] <= wdata_i;
    end
  end

  // Buffered block for the consistency compare
  assign rdata_o = blk_q[addr_i];

  // Hide contents while locked
  assign data_o = locked_i ? DataDefault : blk_q;

  // Digest is never gated
  assign digest_o = blk_q[NumBlocks-1];

endmodule

//--- source/part_fsm.sv
////////////////////////////////////////////////////////////////////////////
// Partition control FSM
// Reads the partition into the buffer on init, re-reads and compares
// it on consistency requests, and latches errors into a terminal state
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module part_fsm
  import part_buf_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  init_req_i,
  input  logic                  cnsty_chk_req_i,
  input  logic                  escalate_en_i,
  input  otp_rsp_t              otp_rsp_i,
  input  logic [BlockWidth-1:0] blk_rdata_i,
  input  logic                  cnt_last_i,
  input  logic                  cnt_err_i,
  output logic                  otp_req_o,
  output logic                  cnt_clr_o,
  output logic                  cnt_en_o,
  output logic                  buf_wr_en_o,
  output logic                  locked_o,
  output logic                  init_done_o,
  output logic                  cnsty_chk_ack_o,
  output otp_err_e              error_o,
  output logic                  fsm_err_o
);

  // Seven states, the eighth code is illegal
  typedef enum logic [2:0] {
    ResetSt         = 3'h0,
    InitSt          = 3'h1,
    InitWaitSt      = 3'h2,
    IdleSt          = 3'h3,
    CnstyReadSt     = 3'h4,
    CnstyReadWaitSt = 3'h5,
    ErrorSt         = 3'h6
  } state_e;

  state_e   state_d, state_q;
  otp_err_e error_d, error_q;
  logic     locked_d, locked_q;
  logic     rsp_ok;

  // Correctable ECC errors let the operation go on
  assign rsp_ok = otp_rsp_i.err inside {NoError, MacroEccCorrError};

  ////////////////////////////////////////////////////////////////////////////
  // Next state logic
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    error_d         = error_q;
    locked_d        = locked_q;
    otp_req_o       = 1'b0;
    cnt_clr_o       = 1'b0;
    cnt_en_o        = 1'b0;
    buf_wr_en_o     = 1'b0;
    cnsty_chk_ack_o = 1'b0;
    fsm_err_o       = 1'b0;

    unique case (state_q)
      // Wait for the init pulse
      ResetSt: begin
        if (init_req_i) begin
          state_d   = InitSt;
          cnt_clr_o = 1'b1;
        end
      end
      // Hold the read request until granted
      InitSt: begin
        otp_req_o = 1'b1;
        if (otp_rsp_i.gnt) begin
          state_d = InitWaitSt;
        end
      end
      // Store the returned block, then next block or idle
      InitWaitSt: begin
        if (otp_rsp_i.rvalid) begin
          if (rsp_ok) begin
            buf_wr_en_o = 1'b1;
            if (otp_rsp_i.err != NoError) begin
              error_d = MacroEccCorrError;
            end
            if (cnt_last_i) begin
              // Digest read, release the buffer
              state_d  = IdleSt;
              locked_d = 1'b0;
            end else begin
              state_d  = InitSt;
              cnt_en_o = 1'b1;
            end
          end else begin
            state_d = ErrorSt;
            error_d = otp_rsp_i.err;
          end
        end
      end
      // Wait for consistency requests
      IdleSt: begin
        if (cnsty_chk_req_i) begin
          state_d   = CnstyReadSt;
          cnt_clr_o = 1'b1;
        end
      end
      CnstyReadSt: begin
        otp_req_o = 1'b1;
        if (otp_rsp_i.gnt) begin
          state_d = CnstyReadWaitSt;
        end
      end
      // Compare the OTP block against the buffered copy
      CnstyReadWaitSt: begin
        if (otp_rsp_i.rvalid) begin
          if (!rsp_ok) begin
            state_d         = ErrorSt;
            error_d         = otp_rsp_i.err;
            cnsty_chk_ack_o = 1'b1;
          end else if (otp_rsp_i.rdata != blk_rdata_i) begin
            state_d         = ErrorSt;
            error_d         = CheckFailError;
            cnsty_chk_ack_o = 1'b1;
          end else begin
            if (otp_rsp_i.err != NoError) begin
              error_d = MacroEccCorrError;
            end
            if (cnt_last_i) begin
              state_d         = IdleSt;
              cnsty_chk_ack_o = 1'b1;
            end else begin
              state_d  = CnstyReadSt;
              cnt_en_o = 1'b1;
            end
          end
        end
      end
      // Terminal state, checks are acked right away
      ErrorSt: begin
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
        cnsty_chk_ack_o = cnsty_chk_req_i;
      end
      // Illegal encoding
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation and counter faults override everything
    if (escalate_en_i || cnt_err_i) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
      if (state_q != ErrorSt) begin
        error_d = FsmStateError;
      end
    end

    // Every way into the error state locks the partition
    if (state_d == ErrorSt) begin
      locked_d = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= ResetSt;
      error_q  <= NoError;
      locked_q <= 1'b1;
    end else begin
      state_q  <= state_d;
      error_q  <= error_d;
      locked_q <= locked_d;
    end
  end

  assign error_o     = error_q;
  assign locked_o    = locked_q;
  // Unlocked only after a clean init
  assign init_done_o = ~locked_q;

  // Escalation lands in the locked terminal state one cycle later
  esc_to_error_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    escalate_en_i |=> (state_q == ErrorSt) && locked_o);

endmodule

//--- test/tb_part_buf.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the buffered OTP partition
// Models the OTP macro, runs init, consistency, lock and escalation tests
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_part_buf
  import part_buf_pkg::*;
();

  localparam int unsigned DriveDelay  = 2;
  localparam int unsigned ReqTimeout  = 16;
  localparam int unsigned DoneTimeout = 64;
  localparam int unsigned AckTimeout  = 32;

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  logic                   init_req_i;
  logic                   init_done_o;
  logic                   cnsty_chk_req_i;
  logic                   cnsty_chk_ack_o;
  logic                   escalate_en_i;
  otp_err_e               error_o;
  logic                   fsm_err_o;
  part_access_t           access_i;
  part_access_t           access_o;
  logic [PartBytes*8-1:0] data_o;
  logic [BlockWidth-1:0]  digest_o;
  otp_req_t               otp_req_o;
  otp_rsp_t               otp_rsp_i;

  // Expected partition contents, block 0 first
  logic [BlockWidth-1:0] exp_blk [NumBlocks];
  logic [31:0]           rng_state  = 32'hc4ac;
  int                    err_count  = 0;
  int                    timeout_count = 0;
  int                    ack_count  = 0;
  int                    req_count  = 0;

  part_buf_top part_buf_top_inst (.*);

  // 40 ns period
  always #20 clk_i = ~clk_i;

  // Acks and cycles with an OTP read request, sampled on the edge
  always @(posedge clk_i) begin
    if (cnsty_chk_ack_o) begin
      ack_count++;
    end
    if (otp_req_o.req) begin
      req_count++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw(output logic [31:0] r);
    rng_state = xorshift(rng_state);
    r = rng_state;
  endtask

  // Inputs change just after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #DriveDelay;
  endtask

  task automatic check_err(input string name, input otp_err_e got, input otp_err_e exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_access(input string name, input part_access_t got,
                              input part_access_t exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_word(input string name, input logic [BlockWidth-1:0] got,
                            input logic [BlockWidth-1:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_addr(input string name, input logic [OtpAddrWidth-1:0] got,
                            input logic [OtpAddrWidth-1:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      err_count++;
    end
  endtask

  // Each block of data_o against the expected blocks or the locked default
  task automatic check_data(input logic expect_default);
    logic [BlockWidth-1:0] exp_word;
    for (int i = 0; i < NumBlocks; i++) begin
      exp_word = expect_default ? DataDefault[i*BlockWidth +: BlockWidth] : exp_blk[i];
      check_word($sformatf("data_o block %0d", i), data_o[i*BlockWidth +: BlockWidth],
                 exp_word);
    end
  endtask

  // Random contents, digest forced to zero or to a non-blank value
  task automatic fill_blocks(input logic zero_digest);
    logic [31:0] hi;
    logic [31:0] lo;
    for (int i = 0; i < NumBlocks; i++) begin
      draw(hi);
      draw(lo);
      exp_blk[i] = {hi, lo};
    end
    exp_blk[NumBlocks-1] = zero_digest ? '0 : (exp_blk[NumBlocks-1] | 64'h1);
  endtask

  task automatic apply_reset();
    rst_ni          = 1'b0;
    init_req_i      = 1'b0;
    cnsty_chk_req_i = 1'b0;
    escalate_en_i   = 1'b0;
    access_i        = '0;
    otp_rsp_i       = '0;
    repeat (3) @(posedge clk_i);
    #DriveDelay;
    rst_ni = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // OTP macro model
  ////////////////////////////////////////////////////////////////////////////

  // Grant after 0 to 3 cycles, then one rvalid cycle with data and error
  task automatic serve_read(input logic [BlockWidth-1:0] rdata, input otp_err_e err,
                            output logic [OtpAddrWidth-1:0] addr, output logic ok);
    int unsigned n;
    logic [31:0] r;
    n    = 0;
    ok   = 1'b1;
    addr = '0;
    while (!otp_req_o.req && n < ReqTimeout) begin
      next_cycle();
      n++;
    end
    if (!otp_req_o.req) begin
      $display("Timeout: no OTP read request within %0d cycles", ReqTimeout);
      timeout_count++;
      ok = 1'b0;
    end else begin
      draw(r);
      repeat (r % 4) next_cycle();
      addr = otp_req_o.addr;
      otp_rsp_i.gnt = 1'b1;
      next_cycle();
      otp_rsp_i.gnt    = 1'b0;
      otp_rsp_i.rvalid = 1'b1;
      otp_rsp_i.rdata  = rdata;
      otp_rsp_i.err    = err;
      next_cycle();
      otp_rsp_i = '0;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequences
  ////////////////////////////////////////////////////////////////////////////

  // Init pulse and n_reads block reads, one of them may carry an error
  task automatic run_init(input int err_idx, input otp_err_e err_code, input int n_reads);
    logic [OtpAddrWidth-1:0] addr;
    logic                    ok;
    ok = 1'b1;
    init_req_i = 1'b1;
    next_cycle();
    init_req_i = 1'b0;
    for (int i = 0; i < n_reads && ok; i++) begin
      serve_read(exp_blk[i], (i == err_idx) ? err_code : NoError, addr, ok);
      // Partition at byte 0x40, eight bytes per block, halfword addressed
      if (ok) check_addr($sformatf("otp_req_o.addr read %0d", i), addr, 10'h20 + 4 * i);
    end
  endtask

  task automatic wait_init_done();
    int unsigned n;
    n = 0;
    while (!init_done_o && n < DoneTimeout) begin
      next_cycle();
      n++;
    end
    if (!init_done_o) begin
      $display("Timeout: init_done_o did not rise within %0d cycles", DoneTimeout);
      timeout_count++;
    end
  endtask

  task automatic wait_ack(input int base);
    int unsigned n;
    n = 0;
    while (ack_count == base && n < AckTimeout) begin
      next_cycle();
      n++;
    end
    if (ack_count == base) begin
      $display("Timeout: no consistency ack within %0d cycles", AckTimeout);
      timeout_count++;
    end
  endtask

  // Full consistency check, bad_idx < 0 means all blocks match
  task automatic run_cnsty_check(input int bad_idx);
    logic [OtpAddrWidth-1:0] addr;
    logic                    ok;
    int                      base;
    int                      n_reads;
    ok      = 1'b1;
    base    = ack_count;
    n_reads = (bad_idx < 0) ? NumBlocks : bad_idx + 1;
    cnsty_chk_req_i = 1'b1;
    for (int i = 0; i < n_reads && ok; i++) begin
      serve_read((i == bad_idx) ? ~exp_blk[i] : exp_blk[i], NoError, addr, ok);
    end
    wait_ack(base);
    cnsty_chk_req_i = 1'b0;
    next_cycle();
    if (ack_count != base + 1) begin
      $display("Expected one consistency ack, saw %0d", ack_count - base);
      err_count++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic init_after_reset();
    apply_reset();
    check_access("access_o", access_o, '{read_lock: 1'b1, write_lock: 1'b1});
    check_data(1'b1);
    check_err("error_o", error_o, NoError);
    check_bit("init_done_o", init_done_o, 1'b0);
    check_bit("fsm_err_o", fsm_err_o, 1'b0);
    fill_blocks(1'b0);
    run_init(-1, NoError, NumBlocks);
    wait_init_done();
    check_data(1'b0);
    check_word("digest_o", digest_o, exp_blk[NumBlocks-1]);
    check_err("error_o", error_o, NoError);
  endtask

  task automatic ecc_errors_on_init();
    // Correctable error on block 1 is only recorded
    apply_reset();
    fill_blocks(1'b0);
    run_init(1, MacroEccCorrError, NumBlocks);
    wait_init_done();
    check_err("error_o", error_o, MacroEccCorrError);
    check_data(1'b0);
    // Uncorrectable error on block 2 stops init
    apply_reset();
    fill_blocks(1'b0);
    run_init(2, MacroEccUncorrError, 3);
    repeat (4) next_cycle();
    check_bit("init_done_o", init_done_o, 1'b0);
    check_err("error_o", error_o, MacroEccUncorrError);
    check_access("access_o", access_o, '{read_lock: 1'b1, write_lock: 1'b1});
    check_data(1'b1);
  endtask

  task automatic cnsty_match();
    apply_reset();
    fill_blocks(1'b0);
    run_init(-1, NoError, NumBlocks);
    wait_init_done();
    run_cnsty_check(-1);
    check_err("error_o", error_o, NoError);
    check_bit("init_done_o", init_done_o, 1'b1);
  endtask

  task automatic cnsty_mismatch();
    int base;
    int reqs;
    apply_reset();
    fill_blocks(1'b0);
    run_init(-1, NoError, NumBlocks);
    wait_init_done();
    run_cnsty_check(2);
    next_cycle();
    check_err("error_o", error_o, CheckFailError);
    check_access("access_o", access_o, '{read_lock: 1'b1, write_lock: 1'b1});
    check_data(1'b1);
    // Error state acks at once without touching OTP
    base = ack_count;
    reqs = req_count;
    cnsty_chk_req_i = 1'b1;
    wait_ack(base);
    cnsty_chk_req_i = 1'b0;
    next_cycle();
    if (ack_count != base + 1 || req_count != reqs) begin
      $display("Request in error state gave %0d acks and %0d OTP request cycles",
               ack_count - base, req_count - reqs);
      err_count++;
    end
  endtask

  task automatic lock_aggregation(input logic zero_digest);
    part_access_t exp_acc;
    apply_reset();
    fill_blocks(zero_digest);
    run_init(-1, NoError, NumBlocks);
    wait_init_done();
    for (int v = 0; v < 4; v++) begin
      access_i = part_access_t'(2'(v));
      next_cycle();
      next_cycle();
      // Non-blank digest keeps the write lock set
      exp_acc = '{read_lock: access_i.read_lock,
                  write_lock: access_i.write_lock | !zero_digest};
      check_access("access_o", access_o, exp_acc);
    end
    access_i = '0;
  endtask

  task automatic escalation_in_idle();
    apply_reset();
    fill_blocks(1'b0);
    run_init(-1, NoError, NumBlocks);
    wait_init_done();
    escalate_en_i = 1'b1;
    // Mid-cycle, fsm_err_o follows the escalation input
    #10;
    check_bit("fsm_err_o", fsm_err_o, 1'b1);
    next_cycle();
    next_cycle();
    escalate_en_i = 1'b0;
    check_err("error_o", error_o, FsmStateError);
    check_bit("init_done_o", init_done_o, 1'b0);
    check_access("access_o", access_o, '{read_lock: 1'b1, write_lock: 1'b1});
  endtask

  initial begin
    rst_ni          = 1'b0;
    init_req_i      = 1'b0;
    cnsty_chk_req_i = 1'b0;
    escalate_en_i   = 1'b0;
    access_i        = '0;
    otp_rsp_i       = '0;
    init_after_reset();
    ecc_errors_on_init();
    cnsty_match();
    cnsty_mismatch();
    lock_aggregation(1'b1);
    lock_aggregation(1'b0);
    escalation_in_idle();
    $display("Errors: %0d, timeouts: %0d", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
